// File: spm_defines.svh
// spm sizing macros for bank count, bank depth and data width.

`ifndef SPM_DEFINES_SVH
`define SPM_DEFINES_SVH

// word-interleaved banks, low word-address bits pick the bank.
`define SPM_N_BANK 4

// depth of each bank in words.
`define SPM_N_WORDS 64

// width of a bus and bank word.
`define SPM_DATA_W 32

`endif

// File: spm_pkg.sv
// spm shared types for bus widths, bank address fields and the port fsm.
`default_nettype none

`include "spm_defines.svh"

package spm_pkg;

  typedef logic [`SPM_DATA_W-1:0]   spm_data_t;  // one bus word.
  typedef logic [`SPM_DATA_W/8-1:0] spm_be_t;    // one enable per byte.

  // full byte address over all banks, 10 bits for 4 x 64 x 4 bytes.
  typedef logic [$clog2(`SPM_N_BANK*`SPM_N_WORDS*`SPM_DATA_W/8)-1:0] spm_addr_t;

  typedef logic [$clog2(`SPM_N_BANK)-1:0]  spm_bank_t;  // byte-address bits 3:2.
  typedef logic [$clog2(`SPM_N_WORDS)-1:0] spm_word_t;  // byte-address bits 9:4.
  typedef logic                            spm_id_t;    // initiator id.

  typedef enum logic [1:0] {
    PORT_IDLE = 2'd0,  // waiting for cyc and stb.
    PORT_REQ  = 2'd1,  // request held until grant.
    PORT_RESP = 2'd2   // response cycle, ack out.
  } port_state_e;

endpackage

`default_nettype wire

// File: bank_sram.sv
// single-port byte-enabled sram bank, one cycle read latency, starts as all ones.
`default_nettype none

`include "spm_defines.svh"

module bank_sram (
  input  wire                      clk_i,
  input  wire                      req_i,
  input  wire                      we_i,
  input  wire spm_pkg::spm_word_t  addr_i,
  input  wire spm_pkg::spm_data_t  wdata_i,
  input  wire spm_pkg::spm_be_t    be_i,
  output spm_pkg::spm_data_t       rdata_o
);

  localparam int unsigned N_BYTES = $bits(spm_pkg::spm_be_t);  // lanes per word.

  // storage array, erased flash style pattern at start.
  spm_pkg::spm_data_t mem_q [`SPM_N_WORDS] = '{default: '1};

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < N_BYTES; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];  // masked byte lane.
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];  // read word lands next cycle.
      end
    end
  end

endmodule

`default_nettype wire

// File: l1_spm.sv
// banked l1 scratchpad: always-granting sram banks with id returned beside the data.
`default_nettype none

`include "spm_defines.svh"

module l1_spm (
  input  wire                                       clk_i,
  input  wire                                       rstn_i,
  input  wire [`SPM_N_BANK-1:0]                     bank_req_i,
  input  wire [`SPM_N_BANK-1:0]                     bank_we_i,
  input  wire [`SPM_N_BANK-1:0]                     bank_id_i,
  input  wire spm_pkg::spm_word_t [`SPM_N_BANK-1:0] bank_word_i,
  input  wire spm_pkg::spm_data_t [`SPM_N_BANK-1:0] bank_wdata_i,
  input  wire spm_pkg::spm_be_t   [`SPM_N_BANK-1:0] bank_be_i,
  output spm_pkg::spm_data_t      [`SPM_N_BANK-1:0] bank_rdata_o,
  output logic                    [`SPM_N_BANK-1:0] bank_rid_o
);

  for (genvar i = 0; i < `SPM_N_BANK; i++) begin : gen_bank
    spm_pkg::spm_id_t rid_q;  // id of last cycle's request.

    // id follows the bank latency so the crossbar can route the response.
    always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
        rid_q <= 1'b0;
      end else begin
        rid_q <= bank_id_i[i];
      end
    end

    assign bank_rid_o[i] = rid_q;

    bank_sram i_bank (
      .clk_i   (clk_i),
      .req_i   (bank_req_i[i]),
      .we_i    (bank_we_i[i]),
      .addr_i  (bank_word_i[i]),
      .wdata_i (bank_wdata_i[i]),
      .be_i    (bank_be_i[i]),
      .rdata_o (bank_rdata_o[i])
    );
  end

  // banks never stall, so a floating req would silently corrupt memory.
  a_req_known: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    !$isunknown(bank_req_i)
  ) else $error("l1_spm: unknown bank request %b", bank_req_i);

endmodule

`default_nettype wire

// File: wb_tcdm_port.sv
// wishbone classic slave port, one bank request per bus cycle, ack with the bank data.
`default_nettype none

module wb_tcdm_port (
  input  wire                     clk_i,
  input  wire                     rstn_i,
  input  wire                     wb_cyc_i,
  input  wire                     wb_stb_i,
  input  wire                     wb_we_i,
  input  wire spm_pkg::spm_addr_t wb_adr_i,
  input  wire spm_pkg::spm_data_t wb_dat_i,
  input  wire spm_pkg::spm_be_t   wb_sel_i,
  output spm_pkg::spm_data_t      wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    tcdm_req_o,
  output logic                    tcdm_we_o,
  output spm_pkg::spm_bank_t      tcdm_bank_o,
  output spm_pkg::spm_word_t      tcdm_word_o,
  output spm_pkg::spm_data_t      tcdm_wdata_o,
  output spm_pkg::spm_be_t        tcdm_be_o,
  input  wire                     tcdm_gnt_i,
  input  wire                     tcdm_rvalid_i,
  input  wire spm_pkg::spm_data_t tcdm_rdata_i
);

  localparam int unsigned BYTE_OFS = $clog2($bits(spm_pkg::spm_be_t));  // 2 ignored bits.
  localparam int unsigned BANK_W   = $bits(spm_pkg::spm_bank_t);
  localparam int unsigned WORD_W   = $bits(spm_pkg::spm_word_t);

  spm_pkg::port_state_e state_q;
  spm_pkg::port_state_e state_d;
  logic                 cycle_start;  // new bus cycle taken in idle.
  logic                 we_q;
  spm_pkg::spm_bank_t   bank_q;
  spm_pkg::spm_word_t   word_q;
  spm_pkg::spm_data_t   wdata_q;
  spm_pkg::spm_be_t     be_q;

  assign cycle_start = (state_q == spm_pkg::PORT_IDLE) && wb_cyc_i && wb_stb_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      spm_pkg::PORT_IDLE: begin
        if (cycle_start) begin
          state_d = spm_pkg::PORT_REQ;
        end
      end
      spm_pkg::PORT_REQ: begin
        if (tcdm_gnt_i) begin
          state_d = spm_pkg::PORT_RESP;  // accepted, data comes next cycle.
        end
      end
      spm_pkg::PORT_RESP: state_d = spm_pkg::PORT_IDLE;
      default:            state_d = spm_pkg::PORT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= spm_pkg::PORT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request fields frozen for the whole arbitration wait.
  always_ff @(posedge clk_i) begin
    if (cycle_start) begin
      we_q    <= wb_we_i;
      bank_q  <= wb_adr_i[BYTE_OFS +: BANK_W];           // low word bits interleave.
      word_q  <= wb_adr_i[BYTE_OFS + BANK_W +: WORD_W];  // row inside the bank.
      wdata_q <= wb_dat_i;
      be_q    <= wb_sel_i;
    end
  end

  assign tcdm_req_o   = (state_q == spm_pkg::PORT_REQ);
  assign tcdm_we_o    = we_q;
  assign tcdm_bank_o  = bank_q;
  assign tcdm_word_o  = word_q;
  assign tcdm_wdata_o = wdata_q;
  assign tcdm_be_o    = be_q;

  assign wb_ack_o = (state_q == spm_pkg::PORT_RESP);         // single cycle strobe.
  assign wb_dat_o = tcdm_rvalid_i ? tcdm_rdata_i : '0;  // zero outside response.

  a_ack_in_cycle: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i)
  ) else $error("wb_tcdm_port: ack without an open bus cycle");

  // the crossbar must answer exactly one cycle after the handshake.
  a_rvalid_timing: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    tcdm_rvalid_i |-> $past(tcdm_req_o && tcdm_gnt_i)
  ) else $error("wb_tcdm_port: rvalid without an accepted request");

endmodule

`default_nettype wire

// File: tcdm_xbar.sv
// crossbar from two initiators to the banks with per-bank round-robin and id-routed responses.
`default_nettype none

`include "spm_defines.svh"

module tcdm_xbar (
  input  wire                                       clk_i,
  input  wire                                       rstn_i,
  input  wire [1:0]                                 req_i,
  input  wire [1:0]                                 we_i,
  input  wire spm_pkg::spm_bank_t [1:0]             bank_i,
  input  wire spm_pkg::spm_word_t [1:0]             word_i,
  input  wire spm_pkg::spm_data_t [1:0]             wdata_i,
  input  wire spm_pkg::spm_be_t   [1:0]             be_i,
  input  wire spm_pkg::spm_data_t [`SPM_N_BANK-1:0] bank_rdata_i,
  input  wire [`SPM_N_BANK-1:0]                     bank_rid_i,
  output logic [1:0]                                gnt_o,
  output logic [1:0]                                rvalid_o,
  output spm_pkg::spm_data_t [1:0]                  rdata_o,
  output logic [`SPM_N_BANK-1:0]                    bank_req_o,
  output logic [`SPM_N_BANK-1:0]                    bank_we_o,
  output spm_pkg::spm_word_t [`SPM_N_BANK-1:0]      bank_word_o,
  output spm_pkg::spm_data_t [`SPM_N_BANK-1:0]      bank_wdata_o,
  output spm_pkg::spm_be_t   [`SPM_N_BANK-1:0]      bank_be_o,
  output logic [`SPM_N_BANK-1:0]                    bank_id_o
);

  localparam int unsigned N_PORT = 2;

  logic [`SPM_N_BANK-1:0][N_PORT-1:0] bank_gnt;  // grant matrix by bank and port.
  logic [N_PORT-1:0]                  rpend_q;   // granted last cycle.
  spm_pkg::spm_bank_t [N_PORT-1:0]    rbank_q;   // bank each port was granted.

  for (genvar b = 0; b < `SPM_N_BANK; b++) begin : gen_bank
    logic [N_PORT-1:0] hit;    // ports targeting this bank.
    spm_pkg::spm_id_t  win;    // selected port.
    spm_pkg::spm_id_t  rr_q;   // last winner here.

    assign hit[0] = req_i[0] && (bank_i[0] == spm_pkg::spm_bank_t'(b));
    assign hit[1] = req_i[1] && (bank_i[1] == spm_pkg::spm_bank_t'(b));

    always_comb begin
      if (&hit) begin
        win = ~rr_q;   // collision goes to the other side.
      end else begin
        win = hit[1];  // lone requester wins.
      end
    end

    // pointer moves on every grant and holds on idle banks.
    always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
        rr_q <= 1'b0;
      end else if (bank_req_o[b]) begin
        rr_q <= win;
      end
    end

    assign bank_req_o[b]   = |hit;
    assign bank_id_o[b]    = win;
    assign bank_we_o[b]    = we_i[win];
    assign bank_word_o[b]  = word_i[win];
    assign bank_wdata_o[b] = wdata_i[win];
    assign bank_be_o[b]    = be_i[win];

    assign bank_gnt[b][0] = hit[0] && !win;
    assign bank_gnt[b][1] = hit[1] && win;
  end

  always_comb begin
    gnt_o = '0;
    for (int b = 0; b < `SPM_N_BANK; b++) begin
      gnt_o = gnt_o | bank_gnt[b];  // each port hits one bank at most.
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rpend_q <= '0;
      rbank_q <= '0;
    end else begin
      rpend_q <= gnt_o;
      for (int p = 0; p < N_PORT; p++) begin
        if (gnt_o[p]) begin
          rbank_q[p] <= bank_i[p];
        end
      end
    end
  end

  for (genvar p = 0; p < N_PORT; p++) begin : gen_resp
    assign rdata_o[p]  = bank_rdata_i[rbank_q[p]];
    // the bank's own returned id must name this port.
    assign rvalid_o[p] = rpend_q[p] &&
                         (bank_rid_i[rbank_q[p]] == spm_pkg::spm_id_t'(p));

    // a waiting port holds req, so the pointer must serve it next.
    a_no_starve: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      (req_i[p] && !gnt_o[p]) |=> gnt_o[p]
    ) else $error("tcdm_xbar: port %0d lost arbitration twice", p);
  end

  // ports granted together must sit on different banks.
  a_one_gnt: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    (&gnt_o) |-> (bank_i[0] != bank_i[1])
  ) else $error("tcdm_xbar: bank %0d granted to both ports", bank_i[0]);

  a_gnt_has_req: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    (gnt_o & ~req_i) == '0
  ) else $error("tcdm_xbar: grant without request %b/%b", gnt_o, req_i);

endmodule

`default_nettype wire

// File: spm_top.sv
// dual wishbone scratchpad top: two bus ports, bank crossbar and banked sram.
`default_nettype none

`include "spm_defines.svh"

module spm_top (
  input  wire                     clk_i,
  input  wire                     rstn_i,
  input  wire                     wb_0_cyc_i,
  input  wire                     wb_0_stb_i,
  input  wire                     wb_0_we_i,
  input  wire spm_pkg::spm_addr_t wb_0_adr_i,
  input  wire spm_pkg::spm_data_t wb_0_dat_i,
  input  wire spm_pkg::spm_be_t   wb_0_sel_i,
  output spm_pkg::spm_data_t      wb_0_dat_o,
  output logic                    wb_0_ack_o,
  input  wire                     wb_1_cyc_i,
  input  wire                     wb_1_stb_i,
  input  wire                     wb_1_we_i,
  input  wire spm_pkg::spm_addr_t wb_1_adr_i,
  input  wire spm_pkg::spm_data_t wb_1_dat_i,
  input  wire spm_pkg::spm_be_t   wb_1_sel_i,
  output spm_pkg::spm_data_t      wb_1_dat_o,
  output logic                    wb_1_ack_o
);

  // port side, index is the initiator id.
  logic [1:0]                 p_req, p_we, p_gnt, p_rvalid;
  spm_pkg::spm_bank_t [1:0]   p_bank;
  spm_pkg::spm_word_t [1:0]   p_word;
  spm_pkg::spm_data_t [1:0]   p_wdata, p_rdata;
  spm_pkg::spm_be_t   [1:0]   p_be;

  // bank side.
  logic [`SPM_N_BANK-1:0]               b_req, b_we, b_id, b_rid;
  spm_pkg::spm_word_t [`SPM_N_BANK-1:0] b_word;
  spm_pkg::spm_data_t [`SPM_N_BANK-1:0] b_wdata, b_rdata;
  spm_pkg::spm_be_t   [`SPM_N_BANK-1:0] b_be;

  wb_tcdm_port i_port0 (
    .clk_i (clk_i), .rstn_i (rstn_i),
    .wb_cyc_i (wb_0_cyc_i), .wb_stb_i (wb_0_stb_i), .wb_we_i (wb_0_we_i),
    .wb_adr_i (wb_0_adr_i), .wb_dat_i (wb_0_dat_i), .wb_sel_i (wb_0_sel_i),
    .wb_dat_o (wb_0_dat_o), .wb_ack_o (wb_0_ack_o),
    .tcdm_req_o (p_req[0]), .tcdm_we_o (p_we[0]), .tcdm_bank_o (p_bank[0]),
    .tcdm_word_o (p_word[0]), .tcdm_wdata_o (p_wdata[0]), .tcdm_be_o (p_be[0]),
    .tcdm_gnt_i (p_gnt[0]), .tcdm_rvalid_i (p_rvalid[0]), .tcdm_rdata_i (p_rdata[0])
  );

  wb_tcdm_port i_port1 (
    .clk_i (clk_i), .rstn_i (rstn_i),
    .wb_cyc_i (wb_1_cyc_i), .wb_stb_i (wb_1_stb_i), .wb_we_i (wb_1_we_i),
    .wb_adr_i (wb_1_adr_i), .wb_dat_i (wb_1_dat_i), .wb_sel_i (wb_1_sel_i),
    .wb_dat_o (wb_1_dat_o), .wb_ack_o (wb_1_ack_o),
    .tcdm_req_o (p_req[1]), .tcdm_we_o (p_we[1]), .tcdm_bank_o (p_bank[1]),
    .tcdm_word_o (p_word[1]), .tcdm_wdata_o (p_wdata[1]), .tcdm_be_o (p_be[1]),
    .tcdm_gnt_i (p_gnt[1]), .tcdm_rvalid_i (p_rvalid[1]), .tcdm_rdata_i (p_rdata[1])
  );

  tcdm_xbar i_xbar (
    .clk_i (clk_i), .rstn_i (rstn_i),
    .req_i (p_req), .we_i (p_we), .bank_i (p_bank),
    .word_i (p_word), .wdata_i (p_wdata), .be_i (p_be),
    .bank_rdata_i (b_rdata), .bank_rid_i (b_rid),
    .gnt_o (p_gnt), .rvalid_o (p_rvalid), .rdata_o (p_rdata),
    .bank_req_o (b_req), .bank_we_o (b_we), .bank_word_o (b_word),
    .bank_wdata_o (b_wdata), .bank_be_o (b_be), .bank_id_o (b_id)
  );

  l1_spm i_spm (
    .clk_i (clk_i), .rstn_i (rstn_i),
    .bank_req_i (b_req), .bank_we_i (b_we), .bank_id_i (b_id),
    .bank_word_i (b_word), .bank_wdata_i (b_wdata), .bank_be_i (b_be),
    .bank_rdata_o (b_rdata), .bank_rid_o (b_rid)
  );

endmodule

`default_nettype wire

// File: tb_spm_top.sv
// testbench for the dual wishbone scratchpad, table driven and random two-port traffic.
`default_nettype none

`include "spm_defines.svh"

module tb_spm_top;

  localparam int ACK_TIMEOUT = 50;  // cycles allowed per bus access.
  localparam int N_MODEL     = `SPM_N_BANK * `SPM_N_WORDS;
  localparam int N_STIM      = 21;
  localparam int N_RAND      = 16;
  localparam int MIN_EDGES   = 3;   // stb to ack, idle, req and resp.

  // port, we, byte address, write data, byte enables.
  localparam logic [47:0] STIM [N_STIM] = '{
    {1'b0, 1'b0, 10'h000, 32'h0000_0000, 4'hF},  // never written, all ones.
    {1'b0, 1'b1, 10'h000, 32'h1111_1111, 4'hF},  // bank 0, word 0.
    {1'b0, 1'b0, 10'h000, 32'h0000_0000, 4'hF},
    {1'b0, 1'b1, 10'h004, 32'h2222_2222, 4'hF},  // bank 1, word 0.
    {1'b0, 1'b0, 10'h004, 32'h0000_0000, 4'hF},
    {1'b1, 1'b1, 10'h008, 32'h3333_3333, 4'hF},  // bank 2, word 0.
    {1'b1, 1'b0, 10'h008, 32'h0000_0000, 4'hF},
    {1'b1, 1'b1, 10'h3FC, 32'hDEAD_BEEF, 4'hF},  // bank 3, top word.
    {1'b1, 1'b0, 10'h3FC, 32'h0000_0000, 4'hF},
    {1'b0, 1'b1, 10'h3F0, 32'h0BAD_F00D, 4'hF},  // bank 0, top word.
    {1'b0, 1'b0, 10'h3F0, 32'h0000_0000, 4'hF},
    {1'b0, 1'b1, 10'h104, 32'h1234_5678, 4'b0101},  // partial on fresh word.
    {1'b0, 1'b0, 10'h104, 32'h0000_0000, 4'hF},
    {1'b0, 1'b1, 10'h020, 32'hA5A5_A5A5, 4'hF},
    {1'b0, 1'b1, 10'h020, 32'h0000_0000, 4'b0101},  // clears bytes 0 and 2.
    {1'b1, 1'b0, 10'h020, 32'h0000_0000, 4'hF},
    {1'b0, 1'b1, 10'h2A8, 32'hCAFE_F00D, 4'hF},  // port 0 writes.
    {1'b1, 1'b0, 10'h2A8, 32'h0000_0000, 4'hF},  // port 1 reads it back.
    {1'b1, 1'b1, 10'h1B4, 32'h8765_4321, 4'b1010},
    {1'b0, 1'b0, 10'h1B4, 32'h0000_0000, 4'hF},
    {1'b0, 1'b0, 10'h3FF, 32'h0000_0000, 4'hF}   // low address bits ignored.
  };

  logic               clk;
  logic               rstn;
  logic               wb0_cyc;
  logic               wb0_stb;
  logic               wb0_we;
  spm_pkg::spm_addr_t wb0_adr;
  spm_pkg::spm_data_t wb0_dat;
  spm_pkg::spm_be_t   wb0_sel;
  spm_pkg::spm_data_t wb0_dat_o;
  logic               wb0_ack;
  logic               wb1_cyc;
  logic               wb1_stb;
  logic               wb1_we;
  spm_pkg::spm_addr_t wb1_adr;
  spm_pkg::spm_data_t wb1_dat;
  spm_pkg::spm_be_t   wb1_sel;
  spm_pkg::spm_data_t wb1_dat_o;
  logic               wb1_ack;

  spm_pkg::spm_data_t ref_mem [N_MODEL];  // reference copy of the whole spm.
  int                 errors;
  int                 timeouts;
  int                 checks;
  integer             seed;

  spm_top i_dut (
    .clk_i      (clk),
    .rstn_i     (rstn),
    .wb_0_cyc_i (wb0_cyc),
    .wb_0_stb_i (wb0_stb),
    .wb_0_we_i  (wb0_we),
    .wb_0_adr_i (wb0_adr),
    .wb_0_dat_i (wb0_dat),
    .wb_0_sel_i (wb0_sel),
    .wb_0_dat_o (wb0_dat_o),
    .wb_0_ack_o (wb0_ack),
    .wb_1_cyc_i (wb1_cyc),
    .wb_1_stb_i (wb1_stb),
    .wb_1_we_i  (wb1_we),
    .wb_1_adr_i (wb1_adr),
    .wb_1_dat_i (wb1_dat),
    .wb_1_sel_i (wb1_sel),
    .wb_1_dat_o (wb1_dat_o),
    .wb_1_ack_o (wb1_ack)
  );

  always #5 clk = ~clk;  // 10 unit period.

  // model slot from the fixed split, bits 3:2 bank and 9:4 word.
  function automatic int word_slot(input spm_pkg::spm_addr_t adr);
    spm_pkg::spm_bank_t bank;
    spm_pkg::spm_word_t word;
    bank = adr[3:2];
    word = adr[9:4];
    return 32'(word) * `SPM_N_BANK + 32'(bank);
  endfunction

  task automatic merge_write(input spm_pkg::spm_addr_t adr, input spm_pkg::spm_data_t dat,
                             input spm_pkg::spm_be_t sel);
    int slot;
    slot = word_slot(adr);
    for (int b = 0; b < $bits(spm_pkg::spm_be_t); b++) begin
      if (sel[b]) begin
        ref_mem[slot][8*b +: 8] = dat[8*b +: 8];  // only enabled lanes.
      end
    end
  endtask

  // sampled at the falling edge, the next rising edge is the one that sees ack.
  task automatic await_ack(input logic port, output spm_pkg::spm_data_t rdata,
                           output int edges);
    logic got;
    got   = 1'b0;
    edges = 0;
    rdata = '0;
    while (!got && edges < ACK_TIMEOUT) begin
      @(negedge clk);
      if ((port ? wb1_ack : wb0_ack) == 1'b1) begin
        got   = 1'b1;
        rdata = port ? wb1_dat_o : wb0_dat_o;
      end
      @(posedge clk);
      edges++;
    end
    if (!got) begin
      $display("port %0d got no ack within %0d cycles at time %0t", port, ACK_TIMEOUT, $time);
      timeouts++;
    end
  endtask

  task automatic port0_access(input logic we, input spm_pkg::spm_addr_t adr,
                              input spm_pkg::spm_data_t dat, input spm_pkg::spm_be_t sel,
                              output spm_pkg::spm_data_t rdata, output int edges);
    wb0_cyc = 1'b1;
    wb0_stb = 1'b1;
    wb0_we  = we;
    wb0_adr = adr;
    wb0_dat = dat;
    wb0_sel = sel;
    await_ack(1'b0, rdata, edges);
    #1;
    wb0_cyc = 1'b0;  // bus cycle closed after ack.
    wb0_stb = 1'b0;
    wb0_we  = 1'b0;
  endtask

  task automatic port1_access(input logic we, input spm_pkg::spm_addr_t adr,
                              input spm_pkg::spm_data_t dat, input spm_pkg::spm_be_t sel,
                              output spm_pkg::spm_data_t rdata, output int edges);
    wb1_cyc = 1'b1;
    wb1_stb = 1'b1;
    wb1_we  = we;
    wb1_adr = adr;
    wb1_dat = dat;
    wb1_sel = sel;
    await_ack(1'b1, rdata, edges);
    #1;
    wb1_cyc = 1'b0;
    wb1_stb = 1'b0;
    wb1_we  = 1'b0;
  endtask

  task automatic check_read(input logic port, input spm_pkg::spm_addr_t adr,
                            input spm_pkg::spm_data_t got);
    spm_pkg::spm_data_t exp;
    exp = ref_mem[word_slot(adr)];
    checks++;
    assert (got === exp) else begin
      $display("FAILED time %0t wb_%0d_dat_o adr %h: expected %h, got %h",
               $time, port, adr, exp, got);
      errors++;
    end
  endtask

  task automatic check_latency(input logic port, input int edges);
    checks++;
    assert (edges >= MIN_EDGES) else begin
      $display("FAILED time %0t wb_%0d_ack_o edge count: expected >= %0d, got %0d",
               $time, port, MIN_EDGES, edges);
      errors++;
    end
  endtask

  initial begin
    logic               s_port;
    logic               s_we;
    spm_pkg::spm_addr_t s_adr;
    spm_pkg::spm_data_t s_dat;
    spm_pkg::spm_be_t   s_sel;
    spm_pkg::spm_data_t rd0;
    spm_pkg::spm_data_t rd1;
    int                 e0;
    int                 e1;
    logic [31:0]        rnd;
    spm_pkg::spm_bank_t bank0;
    spm_pkg::spm_bank_t bank1;
    spm_pkg::spm_word_t word1;
    spm_pkg::spm_addr_t adr0;
    spm_pkg::spm_addr_t adr1;
    spm_pkg::spm_data_t dat0;
    spm_pkg::spm_data_t dat1;
    clk      = 1'b0;
    rstn     = 1'b0;
    wb0_cyc  = 1'b0;
    wb0_stb  = 1'b0;
    wb0_we   = 1'b0;
    wb0_adr  = '0;
    wb0_dat  = '0;
    wb0_sel  = '0;
    wb1_cyc  = 1'b0;
    wb1_stb  = 1'b0;
    wb1_we   = 1'b0;
    wb1_adr  = '0;
    wb1_dat  = '0;
    wb1_sel  = '0;
    errors   = 0;
    timeouts = 0;
    checks   = 0;
    seed     = 32'h16155247;
    for (int i = 0; i < N_MODEL; i++) begin
      ref_mem[i] = '1;  // banks start erased.
    end
    repeat (16) @(posedge clk);
    #1 rstn = 1'b1;

    // directed table, one port at a time.
    for (int i = 0; i < N_STIM; i++) begin
      {s_port, s_we, s_adr, s_dat, s_sel} = STIM[i];
      if (s_port) begin
        port1_access(s_we, s_adr, s_dat, s_sel, rd0, e0);
      end else begin
        port0_access(s_we, s_adr, s_dat, s_sel, rd0, e0);
      end
      if (s_we) begin
        merge_write(s_adr, s_dat, s_sel);
      end else begin
        check_read(s_port, s_adr, rd0);
      end
      check_latency(s_port, e0);
    end

    // both ports at once, even rounds collide on one bank.
    for (int i = 0; i < N_RAND; i++) begin
      rnd   = $random(seed);
      bank0 = rnd[1:0];
      if (i % 2 == 0) begin
        bank1 = bank0;
        word1 = ~rnd[7:2];  // other word, same bank.
      end else begin
        bank1 = bank0 ^ ((rnd[9:8] == 2'd0) ? 2'd1 : rnd[9:8]);
        word1 = rnd[15:10];
      end
      adr0 = {rnd[7:2], bank0, 2'b00};
      adr1 = {word1, bank1, 2'b00};
      dat0 = $random(seed);
      dat1 = $random(seed);
      fork
        port0_access(1'b1, adr0, dat0, rnd[19:16], rd0, e0);
        port1_access(1'b1, adr1, dat1, rnd[23:20], rd1, e1);
      join
      merge_write(adr0, dat0, rnd[19:16]);
      merge_write(adr1, dat1, rnd[23:20]);
      check_latency(1'b0, e0);
      check_latency(1'b1, e1);
      fork
        port0_access(1'b0, adr0, '0, 4'hF, rd0, e0);
        port1_access(1'b0, adr1, '0, 4'hF, rd1, e1);
      join
      check_read(1'b0, adr0, rd0);
      check_read(1'b1, adr1, rd1);
      check_latency(1'b0, e0);
      check_latency(1'b1, e1);
    end

    $display("tb_spm_top: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
spm_pkg.sv
bank_sram.sv
l1_spm.sv
wb_tcdm_port.sv
tcdm_xbar.sv
spm_top.sv
tb_spm_top.sv

// File: Makefile
# Verilator build, run, lint and clean for the dual-port scratchpad.

TOP := tb_spm_top

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

obj_dir/V$(TOP): verilog.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

lint:
	verilator --lint-only -Wall +incdir+. --top-module spm_top \
	  spm_pkg.sv bank_sram.sv l1_spm.sv wb_tcdm_port.sv tcdm_xbar.sv spm_top.sv

clean:
	rm -rf obj_dir
